//--- Bender.yml
package:
  name: branch_unit

sources:
  - include_dirs:
      - src
    files:
      - src/bpu_pkg.sv
      - src/jmp_req_if.sv
      - src/bpu_predictor.sv
      - src/core_jmp.sv
      - src/bpu_update.sv
      - src/branch_unit_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_branch_unit.sv

//--- dv/tb_branch_unit.sv
`include "bpu_params.svh"

module tb_branch_unit;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CYCLES = 2000; // About 60 branches at 6 cycles each, with margin

   logic                          clk = 1'b0;
   logic                          reset_i;
   logic                          issue_valid_i;
   logic [31:0]                   pc_i;
   logic [31:0]                   target_i;
   bpu_pkg::target_type_e         target_type_i;
   bpu_pkg::cmp_op_e              cmp_type_i;
   logic [31:0]                   r0_i;
   logic [31:0]                   r1_i;
   logic                          flush_o;
   logic [31:0]                   redirect_pc_o;
   logic                          taken_o;
   logic                          resolve_valid_o;
   logic [`BPU_MISS_CNT_BITS-1:0] miss_count_o;

   // Reference state
   logic [1:0]                   m_pht [1 << `BPU_PHT_BITS];
   logic [`BPU_GHR_BITS-1:0]     m_ghr;
   logic [31:0]                  m_ras [`BPU_RAS_DEPTH];
   logic [`BPU_RAS_PTR_BITS-1:0] m_ptr;
   logic [`BPU_MISS_CNT_BITS-1:0] m_misses;

   int    seed = 45;
   int    cycle_count = 0;
   int    errors = 0;
   int    err_mark;
   int    tests_run = 0;
   int    tests_failed = 0;
   string cur_test;

   bpu_pkg::cmp_op_e cmp_codes [8] = '{
      bpu_pkg::CMP_NEVER, bpu_pkg::CMP_EQ, bpu_pkg::CMP_NE, bpu_pkg::CMP_LT,
      bpu_pkg::CMP_GE, bpu_pkg::CMP_LTU, bpu_pkg::CMP_GEU, bpu_pkg::CMP_ALWAYS
   };

   branch_unit_top u_branch_unit_top (
      .clk             (clk),
      .reset_i         (reset_i),
      .issue_valid_i   (issue_valid_i),
      .pc_i            (pc_i),
      .target_i        (target_i),
      .target_type_i   (target_type_i),
      .cmp_type_i      (cmp_type_i),
      .r0_i            (r0_i),
      .r1_i            (r1_i),
      .flush_o         (flush_o),
      .redirect_pc_o   (redirect_pc_o),
      .taken_o         (taken_o),
      .resolve_valid_o (resolve_valid_o),
      .miss_count_o    (miss_count_o)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_pc(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input logic [`BPU_MISS_CNT_BITS-1:0] exp,
                              input logic [`BPU_MISS_CNT_BITS-1:0] act);
      if (act !== exp) begin
         $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err_mark = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != err_mark) begin
         tests_failed++;
         $display("%s: FAIL (%0d errors)", cur_test, errors - err_mark);
      end else begin
         $display("%s: pass", cur_test);
      end
   endtask

   // r1 against r0, bit 0 picks signed
   function automatic logic expected_taken(input bpu_pkg::cmp_op_e op,
                                           input logic [31:0] r0, input logic [31:0] r1);
      logic gt;
      logic lt;
      if (op[0]) begin
         gt = $signed(r1) > $signed(r0);
         lt = $signed(r1) < $signed(r0);
      end else begin
         gt = r1 > r0;
         lt = r1 < r0;
      end
      return (op[3] & gt) | (op[2] & (r1 == r0)) | (op[1] & lt);
   endfunction

   // Issue one branch, check it two cycles later, then step the model
   task automatic run_branch(input logic [31:0] pc, input logic [31:0] tgt,
                             input bpu_pkg::target_type_e tt, input bpu_pkg::cmp_op_e op,
                             input logic [31:0] r0, input logic [31:0] r1);
      logic [`BPU_PHT_BITS-1:0]     idx;
      logic [`BPU_RAS_PTR_BITS-1:0] top;
      logic                         pred_taken;
      logic                         act_taken;
      logic                         miss;
      logic [31:0]                  pred_pc;
      top        = m_ptr - 3'd1;
      idx        = pc[2 +: `BPU_PHT_BITS] ^ m_ghr;
      pred_taken = tt == bpu_pkg::TGT_CALL || tt == bpu_pkg::TGT_RETURN ||
                   op == bpu_pkg::CMP_ALWAYS || m_pht[idx][1];
      pred_pc    = (tt == bpu_pkg::TGT_RETURN) ? m_ras[top] : tgt;
      act_taken  = expected_taken(op, r0, r1);
      miss       = (pred_taken || act_taken) && (pred_taken != act_taken || pred_pc != tgt);
      @(posedge clk);
      issue_valid_i <= 1'b1;
      pc_i          <= pc;
      target_i      <= tgt;
      target_type_i <= tt;
      cmp_type_i    <= op;
      r0_i          <= r0;
      r1_i          <= r1;
      @(posedge clk);
      issue_valid_i <= 1'b0;
      @(posedge clk);
      @(negedge clk); // Middle of the result cycle
      check_bit("resolve_valid_o", 1'b1, resolve_valid_o);
      check_bit("taken_o", act_taken, taken_o);
      check_bit("flush_o", miss, flush_o);
      check_pc("redirect_pc_o", act_taken ? tgt : pc + 32'd4, redirect_pc_o);
      if (act_taken && m_pht[idx] != 2'b11)
         m_pht[idx] = m_pht[idx] + 2'd1;
      else if (!act_taken && m_pht[idx] != 2'b00)
         m_pht[idx] = m_pht[idx] - 2'd1;
      m_ghr = {m_ghr[`BPU_GHR_BITS-2:0], act_taken};
      if (tt == bpu_pkg::TGT_CALL) begin
         m_ras[m_ptr] = pc + 32'd4;
         m_ptr        = m_ptr + 3'd1;
      end else if (tt == bpu_pkg::TGT_RETURN) begin
         m_ptr = top;
      end
      if (miss)
         m_misses = m_misses + 1'b1;
      repeat (3) @(posedge clk); // Tables settle before the next branch
   endtask

   task automatic test_reset_state();
      begin_test("reset_state");
      @(negedge clk);
      check_bit("flush_o", 1'b0, flush_o);
      check_bit("resolve_valid_o", 1'b0, resolve_valid_o);
      check_count("miss_count_o", '0, miss_count_o);
      end_test();
   endtask

   task automatic test_compare_codes();
      logic [31:0] a;
      logic [31:0] b;
      begin_test("compare_resolution");
      for (int c = 0; c < 8; c++) begin
         for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = (k == 0) ? a : $random(seed); // Equal operands once per code
            run_branch(32'h1000 + 32'(c * 64 + k * 4), 32'h2000 + 32'(c * 16),
                       bpu_pkg::TGT_IMM, cmp_codes[c], a, b);
         end
      end
      end_test();
   endtask

   task automatic test_counter_training();
      begin_test("counter_training");
      for (int n = 0; n < 10; n++)
         run_branch(32'h0000_4040, 32'h0000_4800, bpu_pkg::TGT_IMM, bpu_pkg::CMP_EQ, 7, 7);
      run_branch(32'h0000_4040, 32'h0000_4800, bpu_pkg::TGT_IMM, bpu_pkg::CMP_EQ, 7, 9);
      end_test();
   endtask

   task automatic test_return_stack();
      begin_test("return_stack");
      run_branch(32'h0000_5000, 32'h0000_6000, bpu_pkg::TGT_CALL, bpu_pkg::CMP_ALWAYS, 0, 0);
      run_branch(32'h0000_6010, 32'h0000_5004, bpu_pkg::TGT_RETURN, bpu_pkg::CMP_ALWAYS, 0, 0);
      run_branch(32'h0000_5100, 32'h0000_7000, bpu_pkg::TGT_CALL, bpu_pkg::CMP_ALWAYS, 0, 0);
      // Return somewhere other than the pushed address
      run_branch(32'h0000_7020, 32'h0000_5200, bpu_pkg::TGT_RETURN, bpu_pkg::CMP_ALWAYS, 0, 0);
      end_test();
   endtask

   task automatic test_fixed_codes();
      begin_test("always_never");
      run_branch(32'h0000_8000, 32'h0000_8400, bpu_pkg::TGT_IMM, bpu_pkg::CMP_ALWAYS, 1, 2);
      run_branch(32'h0000_8100, 32'h0000_8500, bpu_pkg::TGT_IMM, bpu_pkg::CMP_ALWAYS, 5, 5);
      run_branch(32'h0000_9000, 32'h0000_9400, bpu_pkg::TGT_NONE, bpu_pkg::CMP_NEVER, 3, 3);
      run_branch(32'h0000_9100, 32'h0000_9500, bpu_pkg::TGT_NONE, bpu_pkg::CMP_NEVER, 4, 8);
      end_test();
   endtask

   task automatic test_miss_count();
      begin_test("miss_count");
      @(negedge clk);
      check_count("miss_count_o", m_misses, miss_count_o);
      end_test();
   endtask

   initial begin
      for (int i = 0; i < (1 << `BPU_PHT_BITS); i++)
         m_pht[i] = 2'b01;
      for (int i = 0; i < `BPU_RAS_DEPTH; i++)
         m_ras[i] = '0;
      m_ghr         = '0;
      m_ptr         = '0;
      m_misses      = '0;
      reset_i       = 1'b1;
      issue_valid_i = 1'b0;
      pc_i          = '0;
      target_i      = '0;
      target_type_i = bpu_pkg::TGT_NONE;
      cmp_type_i    = bpu_pkg::CMP_NEVER;
      r0_i          = '0;
      r1_i          = '0;
      repeat (3) @(posedge clk);
      reset_i <= 1'b0;

      test_reset_state();
      test_compare_codes();
      test_counter_training();
      test_return_stack();
      test_fixed_codes();
      test_miss_count();

      $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+src
src/bpu_pkg.sv
src/jmp_req_if.sv
src/bpu_predictor.sv
src/core_jmp.sv
src/bpu_update.sv
src/branch_unit_top.sv
dv/tb_branch_unit.sv

//--- src/bpu_params.svh
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// Pattern history table index width (64 counters)
`define BPU_PHT_BITS 6

// Global history is as wide as the table index so the two can be XORed
`define BPU_GHR_BITS `BPU_PHT_BITS

// Return address stack
`define BPU_RAS_DEPTH 8
`define BPU_RAS_PTR_BITS 3

// Saturating misprediction counter
`define BPU_MISS_CNT_BITS 16

`endif

//--- src/bpu_pkg.sv
`include "bpu_params.svh"

package bpu_pkg;

   typedef enum logic [1:0] {
      TGT_NONE   = 2'd0,
      TGT_CALL   = 2'd1,
      TGT_RETURN = 2'd2,
      TGT_IMM    = 2'd3
   } target_type_e;

   // Bit 0 selects signed compare
   // Bits 3..1 mask the r1 > r0, r1 == r0 and r1 < r0 results
   typedef enum logic [3:0] {
      CMP_NEVER  = 4'b0000,
      CMP_LTU    = 4'b0010,
      CMP_LT     = 4'b0011,
      CMP_EQ     = 4'b0100,
      CMP_NE     = 4'b1010,
      CMP_GEU    = 4'b1100,
      CMP_GE     = 4'b1101,
      CMP_ALWAYS = 4'b1110
   } cmp_op_e;

   typedef struct packed {
      logic                         taken;
      logic [31:0]                  predict_pc;
      logic                         dir_type;     // Predicted conditional
      target_type_e                 target_type;
      logic [`BPU_GHR_BITS-1:0]     history;      // GHR at lookup
      logic [`BPU_RAS_PTR_BITS-1:0] ras_ptr;      // Before any push
   } bpu_predict_t;

   typedef struct packed {
      logic                         miss;
      logic [31:0]                  pc;
      logic                         true_taken;
      logic [31:0]                  true_target;
      logic [`BPU_GHR_BITS-1:0]     history;
      logic                         miss_dir_type;
      logic                         true_dir;
      logic                         miss_target_type;
      target_type_e                 true_target_type;
      logic [`BPU_RAS_PTR_BITS-1:0] ras_ptr;
   } bpu_correct_t;

endpackage

//--- src/bpu_predictor.sv
`include "bpu_params.svh"

module bpu_predictor (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  issue_valid_i,
   input  logic [31:0]           pc_i,
   input  logic [31:0]           target_i,
   input  bpu_pkg::target_type_e target_type_i,
   input  bpu_pkg::cmp_op_e      cmp_type_i,
   input  logic [31:0]           r0_i,
   input  logic [31:0]           r1_i,
   input  logic                  upd_valid_i,
   input  bpu_pkg::bpu_correct_t upd_i,
   jmp_req_if.source             req
);

   localparam int unsigned PHT_ENTRIES = 1 << `BPU_PHT_BITS;

   logic [1:0]                   pht_q [PHT_ENTRIES];
   logic [`BPU_GHR_BITS-1:0]     ghr_q;
   logic [31:0]                  ras_q [`BPU_RAS_DEPTH];
   logic [`BPU_RAS_PTR_BITS-1:0] ras_ptr_q;
   logic [`BPU_RAS_PTR_BITS-1:0] ras_top;
   logic [`BPU_RAS_PTR_BITS-1:0] restore_ptr;
   logic [`BPU_PHT_BITS-1:0]     rd_idx;
   logic [`BPU_PHT_BITS-1:0]     wr_idx;
   logic [1:0]                   wr_cnt;
   logic                         is_call;
   logic                         is_return;
   logic                         force_taken;
   logic                         is_cond;
   bpu_pkg::bpu_predict_t        predict;

   assign is_call   = issue_valid_i && target_type_i == bpu_pkg::TGT_CALL;
   assign is_return = issue_valid_i && target_type_i == bpu_pkg::TGT_RETURN;
   assign ras_top   = ras_ptr_q - 1'b1;

   // Gshare lookup
   assign rd_idx = pc_i[2 +: `BPU_PHT_BITS] ^ ghr_q;
   assign wr_idx = upd_i.pc[2 +: `BPU_PHT_BITS] ^ upd_i.history;

   assign force_taken = target_type_i == bpu_pkg::TGT_CALL ||
                        target_type_i == bpu_pkg::TGT_RETURN ||
                        cmp_type_i == bpu_pkg::CMP_ALWAYS;
   assign is_cond = (|cmp_type_i[3:1]) && !(&cmp_type_i[3:1]);

   always_comb begin
      predict.taken       = force_taken || pht_q[rd_idx][1];
      predict.predict_pc  = (target_type_i == bpu_pkg::TGT_RETURN) ? ras_q[ras_top] : target_i;
      predict.dir_type    = is_cond;
      predict.target_type = target_type_i;
      predict.history     = ghr_q;
      predict.ras_ptr     = ras_ptr_q;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         req.valid <= 1'b0;
      end else begin
         req.valid <= issue_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      req.pc          <= pc_i;
      req.target      <= target_i;
      req.target_type <= target_type_i;
      req.cmp_type    <= cmp_type_i;
      req.r0          <= r0_i;
      req.r1          <= r1_i;
      req.predict     <= predict;
   end

   // Saturating 2-bit counter step
   always_comb begin
      wr_cnt = pht_q[wr_idx];
      if (upd_i.true_taken && wr_cnt != 2'b11) begin
         wr_cnt = wr_cnt + 2'd1;
      end else if (!upd_i.true_taken && wr_cnt != 2'b00) begin
         wr_cnt = wr_cnt - 2'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < PHT_ENTRIES; i++) begin
            pht_q[i] <= 2'b01; // Weakly not taken
         end
      end else if (upd_valid_i) begin
         pht_q[wr_idx] <= wr_cnt;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ghr_q <= '0;
      end else if (upd_valid_i) begin
         if (upd_i.miss) begin
            ghr_q <= {upd_i.history[`BPU_GHR_BITS-2:0], upd_i.true_taken};
         end else begin
            ghr_q <= {ghr_q[`BPU_GHR_BITS-2:0], upd_i.true_taken};
         end
      end
   end

   // Pointer after the missed branch's own push or pop
   always_comb begin
      case (upd_i.true_target_type)
         bpu_pkg::TGT_CALL:   restore_ptr = upd_i.ras_ptr + 1'b1;
         bpu_pkg::TGT_RETURN: restore_ptr = upd_i.ras_ptr - 1'b1;
         default:             restore_ptr = upd_i.ras_ptr;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ras_ptr_q <= '0;
      end else if (upd_valid_i && upd_i.miss) begin
         ras_ptr_q <= restore_ptr; // Redirect wins over a wrong-path issue
      end else if (is_call) begin
         ras_ptr_q <= ras_ptr_q + 1'b1;
      end else if (is_return) begin
         ras_ptr_q <= ras_top;
      end
   end

   always_ff @(posedge clk) begin
      if (is_call) begin
         ras_q[ras_ptr_q] <= pc_i + 32'd4;
      end
   end

   // Record comes back from bpu_update two cycles after issue
   a_upd_pc_known: assert property (@(posedge clk) disable iff (reset_i)
      upd_valid_i |-> !$isunknown(upd_i.pc));

endmodule

//--- src/bpu_update.sv
`include "bpu_params.svh"

module bpu_update (
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          res_valid_i,
   input  bpu_pkg::bpu_correct_t         correct_i,
   output logic                          upd_valid_o,
   output bpu_pkg::bpu_correct_t         upd_o,
   output logic                          flush_o,
   output logic [31:0]                   redirect_pc_o,
   output logic                          taken_o,
   output logic [`BPU_MISS_CNT_BITS-1:0] miss_count_o
);

   logic [31:0] next_pc;
   logic        count_en;

   // Fall through when resolved not taken
   assign next_pc  = correct_i.true_taken ? correct_i.true_target : correct_i.pc + 32'd4;
   assign count_en = res_valid_i && correct_i.miss && !(&miss_count_o);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         upd_valid_o  <= 1'b0;
         flush_o      <= 1'b0;
         miss_count_o <= '0;
      end else begin
         upd_valid_o <= res_valid_i;
         flush_o     <= res_valid_i && correct_i.miss;
         if (count_en) begin
            miss_count_o <= miss_count_o + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (res_valid_i) begin
         upd_o         <= correct_i;
         redirect_pc_o <= next_pc;
      end
   end

   assign taken_o = upd_o.true_taken;

   // Flush always carries a known redirect
   a_flush_pc_known: assert property (@(posedge clk) disable iff (reset_i)
      flush_o |-> !$isunknown(redirect_pc_o));

endmodule

//--- src/branch_unit_top.sv
`include "bpu_params.svh"

module branch_unit_top (
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          issue_valid_i,
   input  logic [31:0]                   pc_i,
   input  logic [31:0]                   target_i,
   input  bpu_pkg::target_type_e         target_type_i,
   input  bpu_pkg::cmp_op_e              cmp_type_i,
   input  logic [31:0]                   r0_i,
   input  logic [31:0]                   r1_i,
   output logic                          flush_o,
   output logic [31:0]                   redirect_pc_o,
   output logic                          taken_o,
   output logic                          resolve_valid_o,
   output logic [`BPU_MISS_CNT_BITS-1:0] miss_count_o
);

   bpu_pkg::bpu_correct_t correct;
   bpu_pkg::bpu_correct_t upd;
   logic                  res_valid;

   jmp_req_if u_jmp_req ();

   bpu_predictor u_bpu_predictor (
      .clk           (clk),
      .reset_i       (reset_i),
      .issue_valid_i (issue_valid_i),
      .pc_i          (pc_i),
      .target_i      (target_i),
      .target_type_i (target_type_i),
      .cmp_type_i    (cmp_type_i),
      .r0_i          (r0_i),
      .r1_i          (r1_i),
      .upd_valid_i   (resolve_valid_o), // Update strobe doubles as resolve valid
      .upd_i         (upd),
      .req           (u_jmp_req.source)
   );

   core_jmp u_core_jmp (
      .clk           (clk),
      .reset_i       (reset_i),
      .req           (u_jmp_req.sink),
      .bpu_correct_o (correct),
      .jmp_o         (res_valid)
   );

   bpu_update u_bpu_update (
      .clk           (clk),
      .reset_i       (reset_i),
      .res_valid_i   (res_valid),
      .correct_i     (correct),
      .upd_valid_o   (resolve_valid_o),
      .upd_o         (upd),
      .flush_o       (flush_o),
      .redirect_pc_o (redirect_pc_o),
      .taken_o       (taken_o),
      .miss_count_o  (miss_count_o)
   );

endmodule

//--- src/core_jmp.sv
module core_jmp (
   input  logic                  clk,
   input  logic                  reset_i,
   jmp_req_if.sink               req,
   output bpu_pkg::bpu_correct_t bpu_correct_o,
   output logic                  jmp_o
);

   logic [32:0] r0_ext;
   logic [32:0] r1_ext;
   logic [3:1]  cmp_result;
   logic [3:1]  cmp_mask;
   logic        true_taken;
   logic        true_dir;
   logic        dir_ok;
   logic        target_ok;
   logic        predict_miss;

   assign cmp_mask = req.cmp_type[3:1];

   // One extra bit makes a single signed compare serve both modes
   assign r0_ext = {req.cmp_type[0] & req.r0[31], req.r0};
   assign r1_ext = {req.cmp_type[0] & req.r1[31], req.r1};

   assign cmp_result[3] = $signed(r1_ext) > $signed(r0_ext);
   assign cmp_result[2] = r1_ext == r0_ext;
   assign cmp_result[1] = $signed(r1_ext) < $signed(r0_ext);

   assign true_taken = |(cmp_result & cmp_mask);
   assign true_dir   = (|cmp_mask) && !(&cmp_mask); // Neither never nor always

   assign dir_ok    = req.predict.taken == true_taken;
   assign target_ok = req.predict.predict_pc == req.target;

   always_comb begin
      predict_miss = 1'b0;
      if (req.valid && (true_taken || req.predict.taken)) begin
         if (!dir_ok) begin
            predict_miss = 1'b1;
         end else begin
            predict_miss = !target_ok; // Both taken
         end
      end
   end

   assign jmp_o = req.valid;

   always_comb begin
      bpu_correct_o.miss             = predict_miss;
      bpu_correct_o.pc               = req.pc;
      bpu_correct_o.true_taken       = true_taken;
      bpu_correct_o.true_target      = req.target;
      bpu_correct_o.history          = req.predict.history;
      bpu_correct_o.miss_dir_type    = req.predict.dir_type != true_dir;
      bpu_correct_o.true_dir         = true_dir;
      bpu_correct_o.miss_target_type = req.predict.target_type != req.target_type;
      bpu_correct_o.true_target_type = req.target_type;
      bpu_correct_o.ras_ptr          = req.predict.ras_ptr;
   end

   // Resolved branch carries a known compare code and prediction
   a_resolve_known: assert property (@(posedge clk) disable iff (reset_i)
      jmp_o |-> !$isunknown({req.cmp_type, req.target_type, req.predict.taken}));

   // Decoder must issue returns with an always-taken compare
   a_return_taken: assert property (@(posedge clk) disable iff (reset_i)
      (req.valid && req.target_type == bpu_pkg::TGT_RETURN) |-> true_taken);

endmodule

//--- src/jmp_req_if.sv
// One predicted branch on its way from the predictor to resolution
interface jmp_req_if;

   logic                  valid;
   logic [31:0]           pc;
   logic [31:0]           target;
   bpu_pkg::target_type_e target_type;
   bpu_pkg::cmp_op_e      cmp_type;
   logic [31:0]           r0;
   logic [31:0]           r1;
   bpu_pkg::bpu_predict_t predict;

   modport source (
      output valid,
      output pc,
      output target,
      output target_type,
      output cmp_type,
      output r0,
      output r1,
      output predict
   );

   modport sink (
      input valid,
      input pc,
      input target,
      input target_type,
      input cmp_type,
      input r0,
      input r1,
      input predict
   );

endinterface
